// File: Makefile
VERILATOR ?= verilator
TOP       ?= axis_fifo_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv logic/*.svh verification/*.sv verification/*.svh)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
+incdir+logic
+incdir+verification
logic/axis_fifo_pkg.sv
logic/axis_if.sv
logic/axis_pack.sv
logic/axis_fifo_mem.sv
logic/axis_unpack.sv
logic/axis_fifo.sv
verification/axis_fifo_tb.sv

// File: logic/axis_fifo.sv
`include "axis_fifo_consts.svh"

module axis_fifo
#(
	parameter C_HAS_KEEP = 0,
	parameter C_HAS_DEST = 0,
	parameter C_HAS_USER = 0,
	parameter C_HAS_LAST = 0
)
(
	input  logic                        s_clk,
	input  logic                        rst_n,

	output logic                        s_full,
	output axis_fifo_pkg::count_t       s_count,

	input  logic [`AXIS_DATA_WIDTH-1:0] s_axis_tdata,
	input  logic [`AXIS_KEEP_WIDTH-1:0] s_axis_tkeep,
	input  logic [`AXIS_DEST_WIDTH-1:0] s_axis_tdest,
	input  logic [`AXIS_USER_WIDTH-1:0] s_axis_tuser,
	input  logic                        s_axis_tlast,
	input  logic                        s_axis_tvalid,
	output logic                        s_axis_tready,

	output logic                        m_empty,

	output logic [`AXIS_DATA_WIDTH-1:0] m_axis_tdata,
	output logic [`AXIS_KEEP_WIDTH-1:0] m_axis_tkeep,
	output logic [`AXIS_DEST_WIDTH-1:0] m_axis_tdest,
	output logic [`AXIS_USER_WIDTH-1:0] m_axis_tuser,
	output logic                        m_axis_tlast,
	output logic                        m_axis_tvalid,
	input  logic                        m_axis_tready
);
	localparam int C_WIDTH = `AXIS_PACKED_WIDTH(C_HAS_KEEP, C_HAS_DEST, C_HAS_USER, C_HAS_LAST);

	axis_fifo_pkg::axis_beat_t s_beat;
	axis_fifo_pkg::axis_beat_t m_beat;
	logic fifo_empty;
	logic out_busy;

	axis_if #(.C_WIDTH(C_WIDTH)) packed_if ();
	axis_if #(.C_WIDTH(C_WIDTH)) stored_if ();

	assign s_beat = '{
		tdata: s_axis_tdata,
		tkeep: s_axis_tkeep,
		tdest: s_axis_tdest,
		tuser: s_axis_tuser,
		tlast: s_axis_tlast
	};

	assign m_axis_tdata = m_beat.tdata;
	assign m_axis_tkeep = m_beat.tkeep;
	assign m_axis_tdest = m_beat.tdest;
	assign m_axis_tuser = m_beat.tuser;
	assign m_axis_tlast = m_beat.tlast;

	// Nothing left on the read side
	assign m_empty = fifo_empty && !out_busy;

	// ----------------------------------------
	// Pipeline

	axis_pack #(
		.C_HAS_KEEP(C_HAS_KEEP),
		.C_HAS_DEST(C_HAS_DEST),
		.C_HAS_USER(C_HAS_USER),
		.C_HAS_LAST(C_HAS_LAST)
	) axis_pack_inst (
		.s_clk(s_clk),
		.rst_n(rst_n),
		.s_axis_beat(s_beat),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.out(packed_if.source)
	);

	axis_fifo_mem #(
		.C_WIDTH(C_WIDTH)
	) axis_fifo_mem_inst (
		.s_clk(s_clk),
		.rst_n(rst_n),
		.in(packed_if.sink),
		.out(stored_if.source),
		.count(s_count),
		.full(s_full),
		.empty(fifo_empty)
	);

	axis_unpack #(
		.C_HAS_KEEP(C_HAS_KEEP),
		.C_HAS_DEST(C_HAS_DEST),
		.C_HAS_USER(C_HAS_USER),
		.C_HAS_LAST(C_HAS_LAST)
	) axis_unpack_inst (
		.s_clk(s_clk),
		.rst_n(rst_n),
		.in(stored_if.sink),
		.m_axis_beat(m_beat),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.busy(out_busy)
	);

endmodule

// File: logic/axis_fifo_consts.svh
`ifndef AXIS_FIFO_CONSTS_SVH
`define AXIS_FIFO_CONSTS_SVH

// ----------------------------------------
// Buffer geometry

// FIFO entries, power of two
`define AXIS_DEPTH 16

// Occupancy count must hold the value AXIS_DEPTH itself
`define AXIS_COUNT_WIDTH ($clog2(`AXIS_DEPTH) + 1)

// ----------------------------------------
// Stream field widths

`define AXIS_DATA_WIDTH 32
`define AXIS_KEEP_WIDTH (`AXIS_DATA_WIDTH / 8)
`define AXIS_DEST_WIDTH 4
`define AXIS_USER_WIDTH 2

// Storage word width, sum of the enabled fields
`define AXIS_PACKED_WIDTH(k, d, u, l) \
	(`AXIS_DATA_WIDTH \
	 + (|(k)) * `AXIS_KEEP_WIDTH \
	 + (|(d)) * `AXIS_DEST_WIDTH \
	 + (|(u)) * `AXIS_USER_WIDTH \
	 + (|(l)))

`endif

// File: logic/axis_fifo_mem.sv
`include "axis_fifo_consts.svh"

module axis_fifo_mem
#(
	parameter int C_WIDTH = 32
)
(
	input  logic                  s_clk,
	input  logic                  rst_n,
	axis_if.sink                  in,
	axis_if.source                out,
	output axis_fifo_pkg::count_t count,
	output logic                  full,
	output logic                  empty
);
	localparam int ADDR_WIDTH = $clog2(`AXIS_DEPTH);

	logic [C_WIDTH-1:0]    mem [`AXIS_DEPTH];
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic                  push;
	logic                  pop;

	assign push = in.handshake;
	assign pop  = out.handshake;

	// ----------------------------------------
	// Flags and handshake

	assign full  = (count == axis_fifo_pkg::count_t'(`AXIS_DEPTH));
	assign empty = (count == '0);

	assign in.tready  = ~full;
	assign out.tvalid = ~empty;
	assign out.tdata  = mem[rd_ptr]; // Head entry, first word falls through

	// ----------------------------------------
	// Storage

	always_ff @(posedge s_clk) begin
		if (push) begin
			mem[wr_ptr] <= in.tdata;
		end
	end

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge s_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, unchanged on simultaneous push and pop
	always_ff @(posedge s_clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ----------------------------------------
	// Checks

	// A refused write is retried with the same word
	a_no_write_full: assert property (@(posedge s_clk) disable iff (!rst_n)
		in.tvalid && full |=> in.tvalid && $stable(in.tdata));

	// Pointer distance matches the count, so empty never hides a stale head
	a_no_read_empty: assert property (@(posedge s_clk) disable iff (!rst_n)
		(wr_ptr - rd_ptr) == count[ADDR_WIDTH-1:0]);

	a_count_bound: assert property (@(posedge s_clk) disable iff (!rst_n)
		count <= axis_fifo_pkg::count_t'(`AXIS_DEPTH));

endmodule

// File: logic/axis_fifo_pkg.sv
`include "axis_fifo_consts.svh"

package axis_fifo_pkg;

	// One full stream beat, every field present
	typedef struct packed {
		logic [`AXIS_DATA_WIDTH-1:0] tdata;
		logic [`AXIS_KEEP_WIDTH-1:0] tkeep;
		logic [`AXIS_DEST_WIDTH-1:0] tdest;
		logic [`AXIS_USER_WIDTH-1:0] tuser;
		logic                        tlast;
	} axis_beat_t;

	// Entries held in the FIFO, 0 to AXIS_DEPTH
	typedef logic [`AXIS_COUNT_WIDTH-1:0] count_t;

	// Register slice occupancy
	typedef enum logic {
		SLICE_EMPTY,
		SLICE_FULL
	} slice_state_t;

endpackage

// File: logic/axis_if.sv
// Internal stream link between pipeline stages.
// Sideband fields are folded into tdata by the packer, so only the
// storage word travels here.
interface axis_if
#(
	parameter int C_WIDTH = 32
);
	logic [C_WIDTH-1:0] tdata;
	logic               tvalid;
	logic               tready;
	logic               handshake; // Beat moves this edge

	assign handshake = tvalid && tready;

	modport source (
		output tdata,
		output tvalid,
		input  tready,
		input  handshake
	);

	modport sink (
		input  tdata,
		input  tvalid,
		output tready,
		input  handshake
	);

endinterface

// File: logic/axis_pack.sv
`include "axis_fifo_consts.svh"

module axis_pack
#(
	parameter C_HAS_KEEP = 0,
	parameter C_HAS_DEST = 0,
	parameter C_HAS_USER = 0,
	parameter C_HAS_LAST = 0
)
(
	input  logic                      s_clk,
	input  logic                      rst_n,
	input  axis_fifo_pkg::axis_beat_t s_axis_beat,
	input  logic                      s_axis_tvalid,
	output logic                      s_axis_tready,
	axis_if.source                    out
);
	// Field offsets inside the storage word, tdata at the bottom
	localparam int KEEP_LSB = `AXIS_DATA_WIDTH;
	localparam int DEST_LSB = KEEP_LSB + (|C_HAS_KEEP) * `AXIS_KEEP_WIDTH;
	localparam int USER_LSB = DEST_LSB + (|C_HAS_DEST) * `AXIS_DEST_WIDTH;
	localparam int LAST_LSB = USER_LSB + (|C_HAS_USER) * `AXIS_USER_WIDTH;
	localparam int C_WIDTH  = `AXIS_PACKED_WIDTH(C_HAS_KEEP, C_HAS_DEST, C_HAS_USER, C_HAS_LAST);

	logic [DEST_LSB-1:0] word_keep;
	logic [USER_LSB-1:0] word_dest;
	logic [LAST_LSB-1:0] word_user;
	logic [C_WIDTH-1:0]  word_d;
	logic [C_WIDTH-1:0]  word_q;

	axis_fifo_pkg::slice_state_t state;
	logic load;

	// ----------------------------------------
	// Packing chain

	if (C_HAS_KEEP) begin : g_keep
		assign word_keep = {s_axis_beat.tkeep, s_axis_beat.tdata};
	end else begin : g_no_keep
		assign word_keep = s_axis_beat.tdata;
	end

	if (C_HAS_DEST) begin : g_dest
		assign word_dest = {s_axis_beat.tdest, word_keep};
	end else begin : g_no_dest
		assign word_dest = word_keep;
	end

	if (C_HAS_USER) begin : g_user
		assign word_user = {s_axis_beat.tuser, word_dest};
	end else begin : g_no_user
		assign word_user = word_dest;
	end

	if (C_HAS_LAST) begin : g_last
		assign word_d = {s_axis_beat.tlast, word_user};
	end else begin : g_no_last
		assign word_d = word_user;
	end

	// ----------------------------------------
	// Input register slice

	assign s_axis_tready = (state == axis_fifo_pkg::SLICE_EMPTY) || out.handshake;
	assign load = s_axis_tvalid && s_axis_tready;

	always_ff @(posedge s_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= axis_fifo_pkg::SLICE_EMPTY;
		end else if (load) begin
			state <= axis_fifo_pkg::SLICE_FULL;
		end else if (out.handshake) begin
			state <= axis_fifo_pkg::SLICE_EMPTY;
		end
	end

	always_ff @(posedge s_clk) begin
		if (load) begin
			word_q <= word_d;
		end
	end

	assign out.tvalid = (state == axis_fifo_pkg::SLICE_FULL);
	assign out.tdata  = word_q;

	// Stalled word must wait unchanged for the FIFO
	a_hold_stable: assert property (@(posedge s_clk) disable iff (!rst_n)
		out.tvalid && !out.tready |=> out.tvalid && $stable(out.tdata));

endmodule

// File: logic/axis_unpack.sv
`include "axis_fifo_consts.svh"

module axis_unpack
#(
	parameter C_HAS_KEEP = 0,
	parameter C_HAS_DEST = 0,
	parameter C_HAS_USER = 0,
	parameter C_HAS_LAST = 0
)
(
	input  logic                      s_clk,
	input  logic                      rst_n,
	axis_if.sink                      in,
	output axis_fifo_pkg::axis_beat_t m_axis_beat,
	output logic                      m_axis_tvalid,
	input  logic                      m_axis_tready,
	output logic                      busy
);
	// Same layout as the packer
	localparam int KEEP_LSB = `AXIS_DATA_WIDTH;
	localparam int DEST_LSB = KEEP_LSB + (|C_HAS_KEEP) * `AXIS_KEEP_WIDTH;
	localparam int USER_LSB = DEST_LSB + (|C_HAS_DEST) * `AXIS_DEST_WIDTH;
	localparam int LAST_LSB = USER_LSB + (|C_HAS_USER) * `AXIS_USER_WIDTH;

	logic [`AXIS_KEEP_WIDTH-1:0] f_keep;
	logic [`AXIS_DEST_WIDTH-1:0] f_dest;
	logic [`AXIS_USER_WIDTH-1:0] f_user;
	logic                        f_last;

	axis_fifo_pkg::slice_state_t state;

	// ----------------------------------------
	// Field extraction, absent fields get defaults

	if (C_HAS_KEEP) begin : g_keep
		assign f_keep = in.tdata[KEEP_LSB +: `AXIS_KEEP_WIDTH];
	end else begin : g_no_keep
		assign f_keep = '1; // All bytes valid
	end

	if (C_HAS_DEST) begin : g_dest
		assign f_dest = in.tdata[DEST_LSB +: `AXIS_DEST_WIDTH];
	end else begin : g_no_dest
		assign f_dest = '0;
	end

	if (C_HAS_USER) begin : g_user
		assign f_user = in.tdata[USER_LSB +: `AXIS_USER_WIDTH];
	end else begin : g_no_user
		assign f_user = '0;
	end

	if (C_HAS_LAST) begin : g_last
		assign f_last = in.tdata[LAST_LSB];
	end else begin : g_no_last
		assign f_last = 1'b1; // Every beat ends a packet
	end

	// ----------------------------------------
	// Output register slice

	assign in.tready = (state == axis_fifo_pkg::SLICE_EMPTY) || m_axis_tready;

	always_ff @(posedge s_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= axis_fifo_pkg::SLICE_EMPTY;
		end else if (in.handshake) begin
			state <= axis_fifo_pkg::SLICE_FULL;
		end else if (m_axis_tready) begin
			state <= axis_fifo_pkg::SLICE_EMPTY; // Held beat taken, nothing new
		end
	end

	always_ff @(posedge s_clk) begin
		if (in.handshake) begin
			m_axis_beat <= '{
				tdata: in.tdata[`AXIS_DATA_WIDTH-1:0],
				tkeep: f_keep,
				tdest: f_dest,
				tuser: f_user,
				tlast: f_last
			};
		end
	end

	assign m_axis_tvalid = (state == axis_fifo_pkg::SLICE_FULL);
	assign busy          = (state == axis_fifo_pkg::SLICE_FULL);

endmodule

// File: verification/axis_fifo_tests.svh
`ifndef AXIS_FIFO_TESTS_SVH
`define AXIS_FIFO_TESTS_SVH

// Every task starts and ends just after a falling edge

task automatic apply_beat(input axis_fifo_pkg::axis_beat_t beat);
	s_axis_tdata  = beat.tdata;
	s_axis_tkeep  = beat.tkeep;
	s_axis_tdest  = beat.tdest;
	s_axis_tuser  = beat.tuser;
	s_axis_tlast  = beat.tlast;
	s_axis_tvalid = 1'b1;
endtask

task automatic send_beat(input axis_fifo_pkg::axis_beat_t beat);
	apply_beat(beat);
	do @(posedge s_clk); while (!s_axis_tready);
	@(negedge s_clk);
endtask

function automatic axis_fifo_pkg::axis_beat_t make_beat(input int idx);
	return '{tdata: 32'hC0DE_0000 + idx, tkeep: 4'(idx), tdest: 4'(idx >> 4),
		tuser: 2'(idx), tlast: idx[0]};
endfunction

task automatic wait_drained();
	s_axis_tvalid = 1'b0;
	m_axis_tready = 1'b1;
	while (expected.size() != 0)
		@(negedge s_clk);
endtask

// ----------------------------------------

task automatic reset_state();
	test_name = "reset_state";
	check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
	check_flag("s_full", 1'b0, s_full);
	check_count("s_count", '0, s_count);
	check_flag("m_empty", 1'b1, m_empty);
endtask

task automatic single_beat();
	test_name = "single_beat";
	m_axis_tready = 1'b1;
	send_beat('{tdata: 32'hA5C3_1E07, tkeep: 4'b1011, tdest: 4'h9, tuser: 2'b11, tlast: 1'b1});
	wait_drained();
	// Input slice, FIFO write, output slice
	check_count("latency", 3, axis_fifo_pkg::count_t'(out_cycle - in_cycle));
endtask

task automatic fill_and_drain();
	int accepted;
	int stalled;
	test_name = "fill_and_drain";
	accepted = 0;
	stalled = 0;
	m_axis_tready = 1'b0;
	while (stalled < 8) begin
		apply_beat(make_beat(accepted)); // Same payload until taken
		@(posedge s_clk);
		if (s_axis_tready) begin
			accepted++;
			stalled = 0;
		end else begin
			stalled++;
		end
		@(negedge s_clk);
	end
	s_axis_tvalid = 1'b0;
	check_count("accepted", axis_fifo_pkg::count_t'(`AXIS_DEPTH + 2),
		axis_fifo_pkg::count_t'(accepted));
	check_flag("s_full", 1'b1, s_full);
	check_count("s_count", axis_fifo_pkg::count_t'(`AXIS_DEPTH), s_count);
	wait_drained();
	check_count("s_count", '0, s_count);
	check_flag("m_empty", 1'b1, m_empty);
endtask

task automatic random_stream();
	logic [31:0] rnd;
	logic [31:0] ctl;
	logic [31:0] rdy;
	logic done;
	test_name = "random_stream";
	rnd = SEED;
	rdy = ~SEED; // Separate sequence for the sink side
	done = 1'b0;
	fork
		begin
			for (int i = 0; i < RANDOM_BEATS; i++) begin
				rnd = lcg_next(rnd);
				ctl = rnd;
				rnd = lcg_next(rnd);
				if (ctl[3:2] == 2'b00) begin
					s_axis_tvalid = 1'b0;
					repeat (ctl[5:4] + 1) @(negedge s_clk);
				end
				send_beat('{tdata: rnd, tkeep: ctl[9:6], tdest: ctl[13:10],
					tuser: ctl[15:14], tlast: (ctl[18:16] == 3'd0)});
			end
			s_axis_tvalid = 1'b0;
			done = 1'b1;
		end
		begin
			while (!done || expected.size() != 0) begin
				rdy = lcg_next(rdy);
				m_axis_tready = (rdy[1:0] != 2'b00);
				@(negedge s_clk);
			end
		end
	join
	wait_drained();
endtask

task automatic steady_flow();
	test_name = "steady_flow";
	m_axis_tready = 1'b0;
	for (int i = 0; i < FLOW_PREFILL; i++)
		send_beat(make_beat(100 + i));
	s_axis_tvalid = 1'b0;
	repeat (4) @(negedge s_clk);
	m_axis_tready = 1'b1;
	for (int i = 0; i < FLOW_BEATS; i++) begin
		send_beat(make_beat(200 + i));
		// One beat in each slice, the rest stay in the FIFO
		check_count("s_count", axis_fifo_pkg::count_t'(FLOW_PREFILL - 2), s_count);
	end
	wait_drained();
endtask

`endif

// File: verification/axis_fifo_tb.sv
`include "axis_fifo_consts.svh"

module axis_fifo_tb;
	localparam int HAS_KEEP = 1;
	localparam int HAS_DEST = 1;
	localparam int HAS_USER = 0;
	localparam int HAS_LAST = 1;
	localparam int RANDOM_BEATS = 200;
	localparam int FLOW_PREFILL = 6;
	localparam int FLOW_BEATS = 40;
	localparam int PLANNED_BEATS = 1 + (`AXIS_DEPTH + 2) + RANDOM_BEATS + FLOW_PREFILL + FLOW_BEATS;
	localparam int TIMEOUT_CYCLES = 20 * PLANNED_BEATS + 500;
	localparam logic [31:0] SEED = 32'h354bc77f;

	logic                        s_clk = 1'b0;
	logic                        rst_n = 1'b0;
	logic                        s_full;
	axis_fifo_pkg::count_t       s_count;
	logic [`AXIS_DATA_WIDTH-1:0] s_axis_tdata = '0;
	logic [`AXIS_KEEP_WIDTH-1:0] s_axis_tkeep = '0;
	logic [`AXIS_DEST_WIDTH-1:0] s_axis_tdest = '0;
	logic [`AXIS_USER_WIDTH-1:0] s_axis_tuser = '0;
	logic                        s_axis_tlast = 1'b0;
	logic                        s_axis_tvalid = 1'b0;
	logic                        s_axis_tready;
	logic                        m_empty;
	logic [`AXIS_DATA_WIDTH-1:0] m_axis_tdata;
	logic [`AXIS_KEEP_WIDTH-1:0] m_axis_tkeep;
	logic [`AXIS_DEST_WIDTH-1:0] m_axis_tdest;
	logic [`AXIS_USER_WIDTH-1:0] m_axis_tuser;
	logic                        m_axis_tlast;
	logic                        m_axis_tvalid;
	logic                        m_axis_tready = 1'b0;

	axis_fifo_pkg::axis_beat_t expected[$]; // Reference model of beats in flight
	string test_name = "none";
	int cycle = 0;
	int checks = 0;
	int mismatches = 0;
	int failures = 0;
	int in_cycle = 0;
	int out_cycle = 0;

	always #2 s_clk = ~s_clk;

	axis_fifo #(
		.C_HAS_KEEP(HAS_KEEP),
		.C_HAS_DEST(HAS_DEST),
		.C_HAS_USER(HAS_USER),
		.C_HAS_LAST(HAS_LAST)
	) axis_fifo_inst (.*);

	// ----------------------------------------
	// Reference rules and compares

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Disabled fields come out as the stream defaults
	function automatic axis_fifo_pkg::axis_beat_t expected_beat(input axis_fifo_pkg::axis_beat_t beat);
		axis_fifo_pkg::axis_beat_t exp;
		exp = beat;
		if (HAS_KEEP == 0) exp.tkeep = '1;
		if (HAS_DEST == 0) exp.tdest = '0;
		if (HAS_USER == 0) exp.tuser = '0;
		if (HAS_LAST == 0) exp.tlast = 1'b1;
		return exp;
	endfunction

	task automatic check_beat(input axis_fifo_pkg::axis_beat_t exp, act);
		checks++;
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH %s beat: expected %h actual %h", test_name, exp, act);
		end
	endtask

	task automatic check_count(input string what, input axis_fifo_pkg::count_t exp, act);
		checks++;
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, act);
		checks++;
		if (exp !== act) begin
			mismatches++;
			$display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic print_summary();
		$display("Summary: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, failures);
	endtask

	// ----------------------------------------
	// Stream monitor and timeout

	always @(posedge s_clk) begin
		cycle++;
		if (cycle > TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			print_summary();
			$display("Verification failed");
			$finish;
		end else if (rst_n) begin
			if (m_axis_tvalid && m_axis_tready) begin
				out_cycle = cycle;
				if (expected.size() == 0) begin
					failures++;
					$display("Test %s: DUT sent a beat that was never accepted", test_name);
				end else begin
					check_beat(expected.pop_front(), {m_axis_tdata, m_axis_tkeep,
						m_axis_tdest, m_axis_tuser, m_axis_tlast});
				end
			end
			if (s_axis_tvalid && s_axis_tready) begin
				in_cycle = cycle;
				expected.push_back(expected_beat({s_axis_tdata, s_axis_tkeep,
					s_axis_tdest, s_axis_tuser, s_axis_tlast}));
			end
		end
	end

	`include "axis_fifo_tests.svh"

	initial begin
		repeat (5) @(posedge s_clk);
		@(negedge s_clk);
		rst_n = 1'b1;
		reset_state();
		single_beat();
		fill_and_drain();
		random_stream();
		steady_flow();
		if (expected.size() != 0) begin
			failures++;
			$display("%0d accepted beats never left the DUT", expected.size());
		end
		print_summary();
		if (mismatches == 0 && failures == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
